// ==== filelist.f ====
hw/snn_pkg.sv
hw/event_fifo.sv
hw/aer_in_decoder.sv
hw/neuron_array.sv
hw/spike_encoder.sv
hw/snn_core_top.sv
verification/snn_core_sva.sv
verification/tb_snn_core.sv

// ==== hw/aer_in_decoder.sv ====
`timescale 1ns/1ps

module aer_in_decoder import snn_pkg::*; #(
    parameter int TIME_STEP = 4,
    parameter int DEPTH     = 4
) (
    input  logic          CLK,
    input  logic          reset,
    input  aer_in_t       aer_in,
    input  logic          aer_in_req,
    output logic          aer_in_ack,
    output neuron_event_t ev,
    output logic          ev_valid,
    input  logic          ev_pop
);

    localparam int TS_W = $clog2(TIME_STEP + 1);

    logic            fifo_full;
    logic            capture;    // word taken this edge
    logic            last_tstep; // this tstep closes the sample
    logic [TS_W-1:0] tstep_cnt;
    neuron_event_t   in_ev;

    // --------------------------------------------------
    // req/ack handshake
    // --------------------------------------------------
    // ack high means the word on the bus was already taken, so the held
    // word is never captured a second time while the sender reacts
    assign capture = aer_in_req && !aer_in_ack && !fifo_full;

    always_ff @(posedge CLK) begin
        if (reset) aer_in_ack <= 1'b0;
        else       aer_in_ack <= capture;  // one cycle pulse per word
    end

    // classify word, tag the sample's last tstep
    assign last_tstep       = aer_in.is_tstep && (tstep_cnt == TS_W'(TIME_STEP - 1));
    assign in_ev.is_tstep   = aer_in.is_tstep;
    assign in_ev.sample_end = last_tstep;
    assign in_ev.addr       = aer_in.addr;

    always_ff @(posedge CLK) begin
        if (reset) begin
            tstep_cnt <= '0;
        end else if (capture && aer_in.is_tstep) begin
            tstep_cnt <= last_tstep ? '0 : tstep_cnt + 1'b1;  // restart per sample
        end
    end

    // pending events, popped by the neuron array
    event_fifo #(
        .DEPTH     (DEPTH),
        .payload_t (neuron_event_t)
    ) i_in_fifo (
        .CLK       (CLK),
        .reset     (reset),
        .push      (capture),
        .push_data (in_ev),
        .full      (fifo_full),
        .pop       (ev_pop),
        .pop_data  (ev),
        .valid     (ev_valid)
    );

endmodule

// ==== hw/event_fifo.sv ====
`timescale 1ns/1ps

module event_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     valid
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];  // storage, no reset
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;       // occupancy
    logic              do_push;
    logic              do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign valid    = (count != '0);
    assign pop_data = mem[rd_ptr];  // head word, stable until popped

    assign do_push = push && !full;  // push into a full fifo is dropped
    assign do_pop  = pop && valid;

    always_ff @(posedge CLK) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    // --------------------------------------------------
    // pointers and count
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

// ==== hw/neuron_array.sv ====
`timescale 1ns/1ps

module neuron_array import snn_pkg::*; #(
    parameter int THRESHOLD = 100
) (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic                      wr_en,
    input  logic [PRE_ADDR_WIDTH-1:0] wr_addr,
    input  weight_row_t               wr_row,
    input  neuron_event_t             ev,
    input  logic                      ev_valid,
    output logic                      ev_pop,
    output step_result_t              step,
    output logic                      step_valid,
    input  logic                      step_ready
);

    localparam logic signed [MEM_WIDTH-1:0] MEM_MAX = {1'b0, {(MEM_WIDTH-1){1'b1}}};
    localparam logic signed [MEM_WIDTH-1:0] MEM_MIN = {1'b1, {(MEM_WIDTH-1){1'b0}}};

    weight_row_t                            weights [N_PRE];  // one row per pre neuron
    weight_row_t                            row;
    logic signed [MEM_WIDTH-1:0]            mem_v   [N_POST];
    logic signed [MEM_WIDTH-1:0]            mem_sum [N_POST];
    logic [SPIKE_CNT_WIDTH-1:0]             cnt     [N_POST];
    logic [N_POST-1:0][SPIKE_CNT_WIDTH-1:0] cnt_next;
    logic [N_POST-1:0]                      fire;
    logic                                   pop_neur;
    logic                                   pop_tstep;

    // clamp at the membrane limits instead of wrapping
    function automatic logic signed [MEM_WIDTH-1:0] sat_add(
        input logic signed [MEM_WIDTH-1:0]    a,
        input logic signed [WEIGHT_WIDTH-1:0] b
    );
        logic signed [MEM_WIDTH:0] s;  // one guard bit
        s = a + b;
        if (s > MEM_MAX)      return MEM_MAX;
        else if (s < MEM_MIN) return MEM_MIN;
        else                  return s[MEM_WIDTH-1:0];
    endfunction

    // --------------------------------------------------
    // weight memory
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        if (wr_en) weights[wr_addr] <= wr_row;
    end

    assign row = weights[ev.addr];

    // address events go straight through, tsteps wait for the encoder
    assign pop_neur  = ev_valid && !ev.is_tstep;
    assign pop_tstep = ev_valid && ev.is_tstep && step_ready;
    assign ev_pop    = pop_neur || pop_tstep;

    always_comb begin
        for (int i = 0; i < N_POST; i++) begin
            mem_sum[i] = sat_add(mem_v[i], $signed(row[i]));
            fire[i]    = (mem_v[i] >= THRESHOLD);  // signed compare
            // counter sticks at all ones
            if (fire[i] && (cnt[i] != '1)) cnt_next[i] = cnt[i] + 1'b1;
            else                           cnt_next[i] = cnt[i];
        end
    end

    // --------------------------------------------------
    // integrate / fire
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < N_POST; i++) begin
                mem_v[i] <= '0;
                cnt[i]   <= '0;
            end
            step_valid <= 1'b0;
        end else begin
            step_valid <= pop_tstep;  // result ready next cycle
            if (pop_neur) begin
                for (int i = 0; i < N_POST; i++) mem_v[i] <= mem_sum[i];
            end else if (pop_tstep) begin
                for (int i = 0; i < N_POST; i++) begin
                    if (ev.sample_end) begin
                        mem_v[i] <= '0;  // fresh sample
                        cnt[i]   <= '0;
                    end else begin
                        if (fire[i]) mem_v[i] <= '0;  // reset on fire
                        cnt[i] <= cnt_next[i];
                    end
                end
            end
        end
    end

    // step result, counts taken before the sample end clear
    always_ff @(posedge CLK) begin
        if (pop_tstep) begin
            step.spikes     <= fire;
            step.counts     <= cnt_next;
            step.sample_end <= ev.sample_end;
        end
    end

endmodule

// ==== hw/snn_core_top.sv ====
`timescale 1ns/1ps

module snn_core_top import snn_pkg::*; #(
    parameter int TIME_STEP = 4,
    parameter int THRESHOLD = 100
) (
    input  logic                      CLK,
    input  logic                      reset,
    // aer in
    input  aer_in_t                   aer_in,
    input  logic                      aer_in_req,
    output logic                      aer_in_ack,
    // weight load
    input  logic                      wr_en,
    input  logic [PRE_ADDR_WIDTH-1:0] wr_addr,
    input  weight_row_t               wr_row,
    // aer out
    output aer_out_t                  aer_out,
    output logic                      aer_out_req,
    input  logic                      aer_out_ack,
    output logic [GOODNESS_WIDTH-1:0] goodness,
    output logic                      one_sample_finish
);

    localparam int IN_DEPTH  = 4;  // input event queue
    localparam int OUT_DEPTH = 4;  // output word queue

    neuron_event_t ev;
    logic          ev_valid;
    logic          ev_pop;
    step_result_t  step;
    logic          step_valid;
    logic          step_ready;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    aer_in_decoder #(
        .TIME_STEP  (TIME_STEP),
        .DEPTH      (IN_DEPTH)
    ) i_decoder (
        .CLK        (CLK),
        .reset      (reset),
        .aer_in     (aer_in),
        .aer_in_req (aer_in_req),
        .aer_in_ack (aer_in_ack),
        .ev         (ev),
        .ev_valid   (ev_valid),
        .ev_pop     (ev_pop)
    );

    // execute
    neuron_array #(
        .THRESHOLD  (THRESHOLD)
    ) i_neurons (
        .CLK        (CLK),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_row     (wr_row),
        .ev         (ev),
        .ev_valid   (ev_valid),
        .ev_pop     (ev_pop),
        .step       (step),
        .step_valid (step_valid),
        .step_ready (step_ready)
    );

    // result
    spike_encoder #(
        .DEPTH             (OUT_DEPTH)
    ) i_encoder (
        .CLK               (CLK),
        .reset             (reset),
        .step              (step),
        .step_valid        (step_valid),
        .step_ready        (step_ready),
        .aer_out           (aer_out),
        .aer_out_req       (aer_out_req),
        .aer_out_ack       (aer_out_ack),
        .goodness          (goodness),
        .one_sample_finish (one_sample_finish)
    );

endmodule

// ==== hw/snn_pkg.sv ====
package snn_pkg;

    // --------------------------------------------------
    // network sizes
    // --------------------------------------------------
    localparam int N_PRE           = 16;  // pre-synaptic neurons
    localparam int PRE_ADDR_WIDTH  = 4;
    localparam int N_POST          = 4;   // post neurons, all updated in parallel
    localparam int POST_ADDR_WIDTH = 2;
    localparam int WEIGHT_WIDTH    = 8;   // signed
    localparam int MEM_WIDTH       = 12;  // signed membrane
    localparam int SPIKE_CNT_WIDTH = 4;
    localparam int GOODNESS_WIDTH  = 16;  // 4 * 15^2 fits easily

    // one weight per post neuron, element i feeds membrane i
    typedef logic [N_POST-1:0][WEIGHT_WIDTH-1:0] weight_row_t;

    // --------------------------------------------------
    // aer words
    // --------------------------------------------------
    typedef struct packed {
        logic                      is_tstep;  // 1: end of time step, addr unused
        logic [PRE_ADDR_WIDTH-1:0] addr;
    } aer_in_t;

    typedef struct packed {
        logic                      is_tstep;
        logic                      sample_end;  // last tstep of the sample
        logic [PRE_ADDR_WIDTH-1:0] addr;
    } neuron_event_t;

    typedef struct packed {
        logic [POST_ADDR_WIDTH-1:0] addr;  // firing post neuron
    } aer_out_t;

    // result of one tstep, handed from neuron array to encoder
    typedef struct packed {
        logic [N_POST-1:0]                      spikes;
        logic [N_POST-1:0][SPIKE_CNT_WIDTH-1:0] counts;  // counts after this step
        logic                                   sample_end;
    } step_result_t;

endpackage

// ==== hw/spike_encoder.sv ====
`timescale 1ns/1ps

module spike_encoder import snn_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic                      CLK,
    input  logic                      reset,
    input  step_result_t              step,
    input  logic                      step_valid,
    output logic                      step_ready,
    output aer_out_t                  aer_out,
    output logic                      aer_out_req,
    input  logic                      aer_out_ack,
    output logic [GOODNESS_WIDTH-1:0] goodness,
    output logic                      one_sample_finish
);

    logic [N_POST-1:0]          pending;   // spikes still to send
    logic [POST_ADDR_WIDTH-1:0] sel_addr;  // lowest pending index
    logic                       out_full;
    logic                       out_valid;
    logic                       push;
    aer_out_t                   push_word;
    logic [GOODNESS_WIDTH-1:0]  c_ext;
    logic [GOODNESS_WIDTH-1:0]  sq_sum;

    // a step in flight also blocks the next tstep
    assign step_ready = (pending == '0) && !step_valid;

    // --------------------------------------------------
    // priority serializer
    // --------------------------------------------------
    always_comb begin
        sel_addr = '0;
        for (int i = N_POST - 1; i >= 0; i--) begin
            if (pending[i]) sel_addr = POST_ADDR_WIDTH'(i);  // lowest wins
        end
    end

    assign push           = (pending != '0) && !out_full;
    assign push_word.addr = sel_addr;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pending <= '0;
        end else if (step_valid) begin
            pending <= step.spikes;  // serializer is empty here
        end else if (push) begin
            pending <= pending & ~(N_POST'(1) << sel_addr);
        end
    end

    // goodness = sum of squared spike counts
    always_comb begin
        sq_sum = '0;
        c_ext  = '0;
        for (int i = 0; i < N_POST; i++) begin
            c_ext  = GOODNESS_WIDTH'(step.counts[i]);
            sq_sum = sq_sum + c_ext * c_ext;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            goodness          <= '0;
            one_sample_finish <= 1'b0;
        end else begin
            one_sample_finish <= step_valid && step.sample_end;
            if (step_valid && step.sample_end) goodness <= sq_sum;  // held till next sample
        end
    end

    // --------------------------------------------------
    // output aer link
    // --------------------------------------------------
    event_fifo #(
        .DEPTH     (DEPTH),
        .payload_t (aer_out_t)
    ) i_out_fifo (
        .CLK       (CLK),
        .reset     (reset),
        .push      (push),
        .push_data (push_word),
        .full      (out_full),
        .pop       (aer_out_ack && out_valid),  // ack pops the head
        .pop_data  (aer_out),
        .valid     (out_valid)
    );

    assign aer_out_req = out_valid;  // req follows fifo occupancy

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the snn core testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_snn_core -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_snn_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished without failure"
exit 0

// ==== verification/snn_core_sva.sv ====
`timescale 1ns/1ps

module snn_core_sva import snn_pkg::*; (
    input logic                      CLK,
    input logic                      reset,
    input logic                      aer_in_req,
    input logic                      aer_in_ack,
    input aer_out_t                  aer_out,
    input logic                      aer_out_req,
    input logic                      aer_out_ack,
    input logic [GOODNESS_WIDTH-1:0] goodness,
    input logic                      one_sample_finish
);

    // --------------------------------------------------
    // aer handshakes
    // --------------------------------------------------
    a_out_hold: assert property (@(posedge CLK) disable iff (reset)
        aer_out_req && !aer_out_ack |=> aer_out_req && $stable(aer_out))
    else $error("aer_out word or req dropped before ack");

    // ack answers the req seen at the capturing edge
    a_ack_needs_req: assert property (@(posedge CLK) disable iff (reset)
        aer_in_ack |-> $past(aer_in_req))
    else $error("aer_in_ack high without a preceding aer_in_req");

    // one capture per held word
    a_ack_single: assert property (@(posedge CLK) disable iff (reset)
        aer_in_ack |=> !aer_in_ack)
    else $error("aer_in_ack high on two cycles in a row");

    // registered outputs quiet right after a reset edge
    a_reset_quiet: assert property (@(posedge CLK)
        reset |=> !aer_in_ack && !aer_out_req && !one_sample_finish && goodness == '0)
    else $error("outputs active during reset");

endmodule

bind snn_core_top snn_core_sva i_sva (
    .CLK               (CLK),
    .reset             (reset),
    .aer_in_req        (aer_in_req),
    .aer_in_ack        (aer_in_ack),
    .aer_out           (aer_out),
    .aer_out_req       (aer_out_req),
    .aer_out_ack       (aer_out_ack),
    .goodness          (goodness),
    .one_sample_finish (one_sample_finish)
);

// ==== verification/tb_snn_core.sv ====
`timescale 1ns/1ps

module tb_snn_core import snn_pkg::*; ();

    localparam int TIME_STEP = 4;
    localparam int THRESHOLD = 100;
    localparam int TIMEOUT   = 2000;                           // cycles per wait
    localparam int MEM_MAX   = (1 << (MEM_WIDTH - 1)) - 1;
    localparam int MEM_MIN   = -(1 << (MEM_WIDTH - 1));
    localparam int CNT_MAX   = (1 << SPIKE_CNT_WIDTH) - 1;

    logic                      CLK;
    logic                      reset;
    aer_in_t                   aer_in;
    logic                      aer_in_req;
    logic                      aer_in_ack;
    logic                      wr_en;
    logic [PRE_ADDR_WIDTH-1:0] wr_addr;
    weight_row_t               wr_row;
    aer_out_t                  aer_out;
    logic                      aer_out_req;
    logic                      aer_out_ack;
    logic [GOODNESS_WIDTH-1:0] goodness;
    logic                      one_sample_finish;

    // reference model state
    int                         w_m   [N_PRE][N_POST];
    int                         mem_m [N_POST];
    int                         cnt_m [N_POST];
    int                         tstep_m;
    logic [POST_ADDR_WIDTH-1:0] exp_q [$];                     // addresses still to come out
    int                         good_q [$];                    // goodness per sample end
    int                         ack_odds = 2;                  // receiver acks 1 in ack_odds cycles
    string                      test_name = "reset";

    snn_core_top #(
        .TIME_STEP (TIME_STEP),
        .THRESHOLD (THRESHOLD)
    ) i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // --------------------------------------------------
    // failure reporting
    // --------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s (test %s)", why, test_name);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string what, input int exp_v, input int act_v);
        $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp_v, act_v);
        stop_run("value check failed");
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int clamp_mem(input int v);
        if (v > MEM_MAX) return MEM_MAX;
        if (v < MEM_MIN) return MEM_MIN;
        return v;
    endfunction

    function automatic void model_event(input aer_in_t w);
        int g;
        if (!w.is_tstep) begin
            for (int i = 0; i < N_POST; i++) mem_m[i] = clamp_mem(mem_m[i] + w_m[w.addr][i]);
        end else begin
            for (int i = 0; i < N_POST; i++) begin
                if (mem_m[i] >= THRESHOLD) begin
                    exp_q.push_back(POST_ADDR_WIDTH'(i));  // ascending order
                    mem_m[i] = 0;
                    if (cnt_m[i] < CNT_MAX) cnt_m[i]++;
                end
            end
            tstep_m++;
            if (tstep_m == TIME_STEP) begin                // sample closes here
                g = 0;
                for (int i = 0; i < N_POST; i++) g += cnt_m[i] * cnt_m[i];
                good_q.push_back(g);
                tstep_m = 0;
                for (int i = 0; i < N_POST; i++) begin
                    mem_m[i] = 0;
                    cnt_m[i] = 0;
                end
            end
        end
    endfunction

    function automatic weight_row_t make_row(input int w0, input int w1, input int w2,
                                             input int w3);
        weight_row_t r;
        r[0] = WEIGHT_WIDTH'(w0);
        r[1] = WEIGHT_WIDTH'(w1);
        r[2] = WEIGHT_WIDTH'(w2);
        r[3] = WEIGHT_WIDTH'(w3);
        return r;
    endfunction

    // --------------------------------------------------
    // stimulus tasks, entered 1 ns after an edge
    // --------------------------------------------------
    task automatic write_row(input int addr, input weight_row_t row);
        wr_en   = 1'b1;
        wr_addr = PRE_ADDR_WIDTH'(addr);
        wr_row  = row;
        @(posedge CLK);
        #1;
        wr_en = 1'b0;
        for (int i = 0; i < N_POST; i++) w_m[addr][i] = $signed(row[i]);
    endtask

    task automatic send_word(input logic is_tstep, input int addr);
        int t;
        aer_in.is_tstep = is_tstep;
        aer_in.addr     = PRE_ADDR_WIDTH'(addr);
        aer_in_req      = 1'b1;                               // held until ack
        t = 0;
        do begin
            @(posedge CLK);
            #1;
            t++;
            if (t > TIMEOUT) stop_run("timeout waiting for aer_in_ack");
        end while (!aer_in_ack);
        aer_in_req = 1'b0;
        model_event(aer_in);                                  // word captured
    endtask

    // input queue and output link empty, every expected result seen
    task automatic wait_idle();
        int t;
        t = 0;
        while (i_dut.i_decoder.ev_valid || aer_out_req ||
               exp_q.size() != 0 || good_q.size() != 0) begin
            @(posedge CLK);
            #1;
            t++;
            if (t > TIMEOUT) stop_run("timeout waiting for the core to drain");
        end
    endtask

    task automatic check_idle();
        assert (!aer_out_req && !aer_in_ack && !one_sample_finish)
        else stop_run("handshake or finish output active around reset");
        assert (goodness == '0) else mismatch("goodness", 0, goodness);
    endtask

    // --------------------------------------------------
    // output receiver, random ack delay
    // --------------------------------------------------
    initial begin : out_monitor
        logic [POST_ADDR_WIDTH-1:0] exp_addr;
        int                         exp_good;
        forever begin
            @(posedge CLK);
            #1;
            aer_out_ack = 1'b0;
            if (!reset && aer_out_req && ($urandom % ack_odds) == 0) begin
                if (exp_q.size() == 0) begin
                    stop_run("output word appeared with no spike expected");
                end else begin
                    exp_addr = exp_q.pop_front();
                    assert (aer_out.addr == exp_addr)
                    else mismatch("aer_out", exp_addr, aer_out.addr);
                    aer_out_ack = 1'b1;                       // pops at next edge
                end
            end
            if (one_sample_finish) begin
                if (good_q.size() == 0) begin
                    stop_run("one_sample_finish without a sample end");
                end else begin
                    exp_good = good_q.pop_front();
                    assert (int'(goodness) == exp_good)
                    else mismatch("goodness", exp_good, goodness);
                end
            end
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h9829));
        reset       = 1'b1;
        aer_in      = '0;
        aer_in_req  = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_row      = '0;
        aer_out_ack = 1'b0;
        repeat (8) begin
            @(posedge CLK);
            #1;
            check_idle();
        end
        reset = 1'b0;
        @(posedge CLK);
        #1;
        check_idle();                                         // first cycle out of reset

        // rows for the directed tests
        write_row(0, make_row(120, 20, 110, -5));
        write_row(1, make_row(40, 0, 0, 0));
        write_row(2, make_row(-128, -128, -128, -128));
        write_row(3, make_row(127, 127, 127, 127));

        test_name = "single_fire";                            // neurons 0 and 2
        send_word(1'b0, 0);
        send_word(1'b1, 0);

        test_name = "accumulate";
        repeat (3) send_word(1'b0, 1);                        // 120 on neuron 0
        send_word(1'b1, 0);
        send_word(1'b1, 0);                                   // nothing left to fire

        test_name = "saturation";                             // wrapping would stay quiet
        repeat (17) send_word(1'b0, 2);
        repeat (17) send_word(1'b0, 3);
        send_word(1'b1, 0);                                   // 4th tstep, sample end
        wait_idle();

        test_name = "sample_end";
        send_word(1'b0, 0);
        send_word(1'b1, 0);
        send_word(1'b0, 0);
        send_word(1'b0, 0);
        repeat (3) send_word(1'b1, 0);
        wait_idle();

        test_name = "back_pressure";
        ack_odds = 4;                                         // slow receiver
        for (int a = 0; a < N_PRE; a++) begin
            write_row(a, make_row(int'($urandom % 128) - 40, int'($urandom % 128) - 40,
                                  int'($urandom % 128) - 40, int'($urandom % 128) - 40));
        end
        repeat (60) send_word(($urandom % 4) == 0, int'($urandom % N_PRE));
        while (tstep_m != 0) send_word(1'b1, 0);              // close the last sample

        test_name = "final";
        wait_idle();
        $display("TB PASSED");
        $finish;
    end

endmodule
